/* flist.f */
common/dual_issue_pkg.sv
common/issue_if.sv
rtl/inst_queue.sv
rtl/regfile.sv
issue/decoder.sv
issue/issue_stage.sv
rtl/alu.sv
rtl/exec_stage.sv
rtl/dual_issue_core.sv
dv/tb_dual_issue_core.sv

/* dv/tb_dual_issue_core.sv */
`timescale 1ns/100ps

module tb_dual_issue_core import dual_issue_pkg::*; ();

    localparam int PUSH_TIMEOUT  = 50;
    localparam int DRAIN_TIMEOUT = 200;

    typedef struct packed {
        logic  burst;
        word_t inst;
    } prog_entry_t;

    // one expected register write, with the registers its instruction reads
    typedef struct packed {
        reg_addr_t   waddr;
        word_t       data;
        logic [31:0] reads;
    } wb_entry_t;

    logic      clk;
    logic      reset_i;
    logic      inst_valid_i;
    logic      inst_ready_o;
    word_t     inst_i;
    logic      wb0_valid_o;
    reg_addr_t wb0_waddr_o;
    word_t     wb0_wdata_o;
    logic      wb1_valid_o;
    reg_addr_t wb1_waddr_o;
    word_t     wb1_wdata_o;

    prog_entry_t program_q [$];
    wb_entry_t   expect_q [$];
    word_t       model_regs [NUM_REGS];
    int          errors;
    int          checks;
    int          seen;

    dual_issue_core u_dual_issue_core (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .inst_i       (inst_i),
        .wb0_valid_o  (wb0_valid_o),
        .wb0_waddr_o  (wb0_waddr_o),
        .wb0_wdata_o  (wb0_wdata_o),
        .wb1_valid_o  (wb1_valid_o),
        .wb1_waddr_o  (wb1_waddr_o),
        .wb1_wdata_o  (wb1_wdata_o)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic word_t r_type(funct_e funct, int rd, int rs, int rt, int shamt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
    endfunction

    function automatic word_t i_type(opcode_e op, int rt, int rs, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic add_inst(input word_t inst, input logic burst);
        prog_entry_t entry;
        entry.burst = burst;
        entry.inst  = inst;
        program_q.push_back(entry);
    endtask

    task automatic build_program();
        add_inst(i_type(OP_ADDIU, 1, 0, 16'h1234), 1'b0);
        add_inst(i_type(OP_ADDIU, 2, 0, 16'hfffb), 1'b0);
        add_inst(i_type(OP_LUI, 3, 0, 16'h8000), 1'b0);
        add_inst(i_type(OP_ORI, 3, 3, 16'h00f0), 1'b0);
        add_inst(i_type(OP_ANDI, 4, 2, 16'hff0f), 1'b0);
        add_inst(i_type(OP_XORI, 5, 2, 16'h8001), 1'b0);
        add_inst(i_type(OP_SLTI, 6, 2, 16'h0001), 1'b0);
        add_inst(i_type(OP_SLTIU, 7, 2, 16'h0001), 1'b0);
        add_inst(i_type(OP_SLTIU, 8, 1, 16'hffff), 1'b0);
        add_inst(r_type(F_ADDU, 9, 1, 2, 0), 1'b0);
        add_inst(r_type(F_SUBU, 10, 1, 2, 0), 1'b0);
        add_inst(r_type(F_AND, 11, 3, 2, 0), 1'b0);
        add_inst(r_type(F_OR, 12, 1, 3, 0), 1'b0);
        add_inst(r_type(F_XOR, 13, 1, 1, 0), 1'b0);
        add_inst(r_type(F_NOR, 14, 0, 0, 0), 1'b0);
        add_inst(r_type(F_SLT, 15, 3, 1, 0), 1'b0);
        add_inst(r_type(F_SLTU, 16, 3, 1, 0), 1'b0);
        add_inst(r_type(F_SLL, 17, 0, 1, 4), 1'b0);
        add_inst(r_type(F_SRL, 18, 0, 3, 8), 1'b0);
        add_inst(r_type(F_SRA, 19, 0, 3, 8), 1'b0);
        // dependency chain, one to three slots apart
        add_inst(i_type(OP_ADDIU, 20, 0, 16'h0007), 1'b0);
        add_inst(r_type(F_ADDU, 21, 20, 20, 0), 1'b1);
        add_inst(r_type(F_ADDU, 22, 21, 20, 0), 1'b1);
        add_inst(r_type(F_SUBU, 23, 22, 20, 0), 1'b1);
        add_inst(i_type(OP_ADDIU, 20, 20, 16'h0001), 1'b1);
        add_inst(i_type(OP_ADDIU, 24, 20, 16'h0000), 1'b1);
        // r0 targets and unknown words write nothing
        add_inst(i_type(OP_ADDIU, 0, 0, 16'h0055), 1'b0);
        add_inst(32'hfc00_0000, 1'b0);
        add_inst(32'h0022_183f, 1'b0);
        add_inst(r_type(F_ADDU, 25, 0, 1, 0), 1'b0);
        add_inst(r_type(F_OR, 0, 1, 2, 0), 1'b0);
        add_inst(r_type(F_ADDU, 26, 0, 0, 0), 1'b0);
        add_inst(r_type(F_ADDU, 31, 3, 0, 0), 1'b0);
        // gap-free burst longer than the queue
        for (int k = 0; k < 12; k++) begin
            add_inst(i_type(OP_ADDIU, 27 + (k % 4),
                            (k % 3 == 0) ? 1 : 27 + ((k + 3) % 4), 16'(k + 1)), 1'b1);
        end
        add_inst(i_type(OP_ADDIU, 29, 0, 16'h0001), 1'b1);
        add_inst(i_type(OP_ADDIU, 29, 0, 16'h0002), 1'b1);
        add_inst(r_type(F_ADDU, 30, 29, 0, 0), 1'b1);
    endtask

    // in-order reference execution of one instruction word
    task automatic model_step(input word_t inst);
        logic [5:0]  op;
        logic [5:0]  funct;
        reg_addr_t   rs, rt, rd, dst;
        logic [4:0]  sh;
        word_t       a, b, simm, zimm, res;
        logic        known;
        logic [31:0] reads;
        wb_entry_t   entry;
        op    = inst[31:26];
        funct = inst[5:0];
        rs    = inst[25:21];
        rt    = inst[20:16];
        rd    = inst[15:11];
        sh    = inst[10:6];
        a     = model_regs[rs];
        b     = model_regs[rt];
        simm  = {{16{inst[15]}}, inst[15:0]};
        zimm  = {16'h0000, inst[15:0]};
        known = 1'b1;
        res   = '0;
        dst   = rt;
        reads = 32'(1) << rs;
        case (op)
            OP_SPECIAL: begin
                dst   = rd;
                reads = (32'(1) << rs) | (32'(1) << rt);
                case (funct)
                    F_SLL:   res = b << sh;
                    F_SRL:   res = b >> sh;
                    F_SRA:   res = $signed(b) >>> sh;
                    F_ADDU:  res = a + b;
                    F_SUBU:  res = a - b;
                    F_AND:   res = a & b;
                    F_OR:    res = a | b;
                    F_XOR:   res = a ^ b;
                    F_NOR:   res = ~(a | b);
                    F_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    F_SLTU:  res = (a < b) ? 32'd1 : 32'd0;
                    default: known = 1'b0;
                endcase
                if (funct[5:2] == 4'b0000) begin
                    reads = 32'(1) << rt;
                end
            end
            OP_ADDIU: res = a + simm;
            OP_SLTI:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            OP_SLTIU: res = (a < simm) ? 32'd1 : 32'd0;
            OP_ANDI:  res = a & zimm;
            OP_ORI:   res = a | zimm;
            OP_XORI:  res = a ^ zimm;
            OP_LUI:   res = {inst[15:0], 16'h0000};
            default:  known = 1'b0;
        endcase
        if (op == OP_LUI) begin
            reads = '0;
        end
        if (known && (dst != 5'd0)) begin
            model_regs[dst] = res;
            entry.waddr     = dst;
            entry.data      = res;
            entry.reads     = reads;
            expect_q.push_back(entry);
        end
    endtask

    task automatic check_idle(input string when_str);
        checks++;
        assert (!wb0_valid_o) else begin
            $display("MISMATCH %0t wb0_valid_o (%s) expected 0 actual %0b",
                     $time, when_str, wb0_valid_o);
            errors++;
        end
        assert (!wb1_valid_o) else begin
            $display("MISMATCH %0t wb1_valid_o (%s) expected 0 actual %0b",
                     $time, when_str, wb1_valid_o);
            errors++;
        end
        assert (inst_ready_o) else begin
            $display("MISMATCH %0t inst_ready_o (%s) expected 1 actual %0b",
                     $time, when_str, inst_ready_o);
            errors++;
        end
    endtask

    task automatic check_write(input string lane, input reg_addr_t waddr, input word_t data);
        wb_entry_t entry;
        checks++;
        seen++;
        assert (expect_q.size() > 0) else begin
            $display("%0t: %s wrote r%0d but no more writes were expected", $time, lane, waddr);
            errors++;
        end
        if (expect_q.size() > 0) begin
            entry = expect_q.pop_front();
            assert (waddr == entry.waddr) else begin
                $display("MISMATCH %0t %s_waddr_o expected %0d actual %0d",
                         $time, lane, entry.waddr, waddr);
                errors++;
            end
            assert (data == entry.data) else begin
                $display("MISMATCH %0t %s_wdata_o expected %08h actual %08h",
                         $time, lane, entry.data, data);
                errors++;
            end
        end
    endtask

    // outputs change on the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (!reset_i) begin
            if (wb0_valid_o) begin
                check_write("wb0", wb0_waddr_o, wb0_wdata_o);
            end
            if (wb0_valid_o && wb1_valid_o) begin
                assert (expect_q.size() == 0 || !expect_q[0].reads[wb0_waddr_o]) else begin
                    $display("%0t: slave reading r%0d was paired with its producer",
                             $time, wb0_waddr_o);
                    errors++;
                end
            end
            if (wb1_valid_o) begin
                check_write("wb1", wb1_waddr_o, wb1_wdata_o);
            end
        end
    end

    task automatic push_word(input word_t word);
        int waited;
        inst_valid_i = 1'b1;
        inst_i       = word;
        waited       = 0;
        while (!inst_ready_o && waited < PUSH_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (inst_ready_o) else begin
            $display("%0t: push timed out waiting for inst_ready_o", $time);
            errors++;
        end
        // accepted on the rising edge in between
        @(negedge clk);
        inst_valid_i = 1'b0;
    endtask

    initial begin
        int waited;
        errors       = 0;
        checks       = 0;
        seen         = 0;
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        void'($urandom(32'h2cb9));
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        build_program();
        foreach (program_q[i]) begin
            model_step(program_q[i].inst);
        end

        repeat (3) begin
            @(negedge clk);
            check_idle("during reset");
        end
        reset_i = 1'b0;
        @(negedge clk);
        check_idle("after reset");

        foreach (program_q[i]) begin
            if (!program_q[i].burst) begin
                repeat ($urandom % 3) @(negedge clk);
            end
            push_word(program_q[i].inst);
        end

        waited = 0;
        while (expect_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (expect_q.size() == 0) else begin
            $display("%0t: timed out with %0d writebacks missing", $time, expect_q.size());
            errors++;
        end
        // a few more cycles so stray writes are caught
        repeat (4) @(negedge clk);

        $display("checks %0d, writebacks %0d, errors %0d", checks, seen, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* rtl/dual_issue_core.sv */
`timescale 1ns/100ps

module dual_issue_core import dual_issue_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      inst_valid_i,
    output logic      inst_ready_o,
    input  word_t     inst_i,
    output logic      wb0_valid_o,
    output reg_addr_t wb0_waddr_o,
    output word_t     wb0_wdata_o,
    output logic      wb1_valid_o,
    output reg_addr_t wb1_waddr_o,
    output word_t     wb1_wdata_o
);

    word_t                head0, head1;
    logic [QUEUE_PTR_W:0] count;
    logic                 pop_one, pop_two;
    reg_addr_t            raddr [4];
    word_t                rdata [4];
    logic                 ex_wen0, ex_wen1;
    reg_addr_t            ex_waddr0, ex_waddr1;
    word_t                ex_result0, ex_result1;

    issue_if u_issue_if ();

    inst_queue u_inst_queue (
        .clk          (clk),
        .reset_i      (reset_i),
        .push_valid_i (inst_valid_i),
        .push_ready_o (inst_ready_o),
        .push_data_i  (inst_i),
        .pop_one_i    (pop_one),
        .pop_two_i    (pop_two),
        .head0_o      (head0),
        .head1_o      (head1),
        .count_o      (count)
    );

    issue_stage u_issue_stage (
        .clk          (clk),
        .reset_i      (reset_i),
        .head0_i      (head0),
        .head1_i      (head1),
        .count_i      (count),
        .pop_one_o    (pop_one),
        .pop_two_o    (pop_two),
        .raddr0_o     (raddr[0]),
        .raddr1_o     (raddr[1]),
        .raddr2_o     (raddr[2]),
        .raddr3_o     (raddr[3]),
        .rdata0_i     (rdata[0]),
        .rdata1_i     (rdata[1]),
        .rdata2_i     (rdata[2]),
        .rdata3_i     (rdata[3]),
        .ex_wen0_i    (ex_wen0),
        .ex_waddr0_i  (ex_waddr0),
        .ex_result0_i (ex_result0),
        .ex_wen1_i    (ex_wen1),
        .ex_waddr1_i  (ex_waddr1),
        .ex_result1_i (ex_result1),
        .wb_wen0_i    (wb0_valid_o),
        .wb_waddr0_i  (wb0_waddr_o),
        .wb_data0_i   (wb0_wdata_o),
        .wb_wen1_i    (wb1_valid_o),
        .wb_waddr1_i  (wb1_waddr_o),
        .wb_data1_i   (wb1_wdata_o),
        .issue_bus    (u_issue_if.issue_mp)
    );

    exec_stage u_exec_stage (
        .clk          (clk),
        .reset_i      (reset_i),
        .issue_bus    (u_issue_if.exec_mp),
        .ex_wen0_o    (ex_wen0),
        .ex_waddr0_o  (ex_waddr0),
        .ex_result0_o (ex_result0),
        .ex_wen1_o    (ex_wen1),
        .ex_waddr1_o  (ex_waddr1),
        .ex_result1_o (ex_result1),
        .wb_valid0_o  (wb0_valid_o),
        .wb_waddr0_o  (wb0_waddr_o),
        .wb_data0_o   (wb0_wdata_o),
        .wb_valid1_o  (wb1_valid_o),
        .wb_waddr1_o  (wb1_waddr_o),
        .wb_data1_o   (wb1_wdata_o)
    );

    // writeback register feeds the register file directly
    regfile u_regfile (
        .clk      (clk),
        .reset_i  (reset_i),
        .raddr0_i (raddr[0]),
        .raddr1_i (raddr[1]),
        .raddr2_i (raddr[2]),
        .raddr3_i (raddr[3]),
        .rdata0_o (rdata[0]),
        .rdata1_o (rdata[1]),
        .rdata2_o (rdata[2]),
        .rdata3_o (rdata[3]),
        .wen0_i   (wb0_valid_o),
        .waddr0_i (wb0_waddr_o),
        .wdata0_i (wb0_wdata_o),
        .wen1_i   (wb1_valid_o),
        .waddr1_i (wb1_waddr_o),
        .wdata1_i (wb1_wdata_o)
    );

endmodule

/* rtl/exec_stage.sv */
`timescale 1ns/100ps

module exec_stage import dual_issue_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    issue_if.exec_mp  issue_bus,
    output logic      ex_wen0_o,
    output reg_addr_t ex_waddr0_o,
    output word_t     ex_result0_o,
    output logic      ex_wen1_o,
    output reg_addr_t ex_waddr1_o,
    output word_t     ex_result1_o,
    output logic      wb_valid0_o,
    output reg_addr_t wb_waddr0_o,
    output word_t     wb_data0_o,
    output logic      wb_valid1_o,
    output reg_addr_t wb_waddr1_o,
    output word_t     wb_data1_o
);

    word_t m_a, s_a;
    word_t m_b, s_b;

    // shifts take rt as the source operand
    assign m_a = issue_bus.master.shift_sel ? issue_bus.master.rt_value
                                            : issue_bus.master.rs_value;
    assign m_b = issue_bus.master.imm_sel ? issue_bus.master.imm_value
                                          : issue_bus.master.rt_value;
    assign s_a = issue_bus.slave.shift_sel ? issue_bus.slave.rt_value
                                           : issue_bus.slave.rs_value;
    assign s_b = issue_bus.slave.imm_sel ? issue_bus.slave.imm_value
                                         : issue_bus.slave.rt_value;

    alu u_alu_master (
        .alu_op_i (issue_bus.master.alu_op),
        .a_i      (m_a),
        .b_i      (m_b),
        .shamt_i  (issue_bus.master.shamt),
        .y_o      (ex_result0_o)
    );

    alu u_alu_slave (
        .alu_op_i (issue_bus.slave.alu_op),
        .a_i      (s_a),
        .b_i      (s_b),
        .shamt_i  (issue_bus.slave.shamt),
        .y_o      (ex_result1_o)
    );

    assign ex_wen0_o   = issue_bus.master.valid && issue_bus.master.wen;
    assign ex_waddr0_o = issue_bus.master.waddr;
    assign ex_wen1_o   = issue_bus.slave.valid && issue_bus.slave.wen;
    assign ex_waddr1_o = issue_bus.slave.waddr;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid0_o <= 1'b0;
            wb_valid1_o <= 1'b0;
        end else begin
            wb_valid0_o <= ex_wen0_o;
            wb_valid1_o <= ex_wen1_o;
        end
    end

    always_ff @(posedge clk) begin
        wb_waddr0_o <= ex_waddr0_o;
        wb_data0_o  <= ex_result0_o;
        wb_waddr1_o <= ex_waddr1_o;
        wb_data1_o  <= ex_result1_o;
    end

endmodule

/* rtl/alu.sv */
`timescale 1ns/100ps

module alu import dual_issue_pkg::*; (
    input  alu_op_e    alu_op_i,
    input  word_t      a_i,
    input  word_t      b_i,
    input  logic [4:0] shamt_i,
    output word_t      y_o
);

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  y_o = a_i + b_i;
            ALU_SUB:  y_o = a_i - b_i;
            ALU_AND:  y_o = a_i & b_i;
            ALU_OR:   y_o = a_i | b_i;
            ALU_XOR:  y_o = a_i ^ b_i;
            ALU_NOR:  y_o = ~(a_i | b_i);
            ALU_SLT:  y_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: y_o = {{(XLEN-1){1'b0}}, a_i < b_i};
            ALU_SLL:  y_o = a_i << shamt_i;
            ALU_SRL:  y_o = a_i >> shamt_i;
            ALU_SRA:  y_o = $signed(a_i) >>> shamt_i;
            // upper half from the immediate
            ALU_LUI:  y_o = {b_i[IMM_MSB:0], {(XLEN-IMM_MSB-1){1'b0}}};
            default:  y_o = '0;
        endcase
    end

endmodule

/* issue/issue_stage.sv */
`timescale 1ns/100ps

module issue_stage import dual_issue_pkg::*; (
    input  logic                 clk,
    input  logic                 reset_i,
    input  word_t                head0_i,
    input  word_t                head1_i,
    input  logic [QUEUE_PTR_W:0] count_i,
    output logic                 pop_one_o,
    output logic                 pop_two_o,
    output reg_addr_t            raddr0_o,
    output reg_addr_t            raddr1_o,
    output reg_addr_t            raddr2_o,
    output reg_addr_t            raddr3_o,
    input  word_t                rdata0_i,
    input  word_t                rdata1_i,
    input  word_t                rdata2_i,
    input  word_t                rdata3_i,
    input  logic                 ex_wen0_i,
    input  reg_addr_t            ex_waddr0_i,
    input  word_t                ex_result0_i,
    input  logic                 ex_wen1_i,
    input  reg_addr_t            ex_waddr1_i,
    input  word_t                ex_result1_i,
    input  logic                 wb_wen0_i,
    input  reg_addr_t            wb_waddr0_i,
    input  word_t                wb_data0_i,
    input  logic                 wb_wen1_i,
    input  reg_addr_t            wb_waddr1_i,
    input  word_t                wb_data1_i,
    issue_if.issue_mp            issue_bus
);

    alu_op_e    m_alu_op, s_alu_op;
    logic       m_shift_sel, s_shift_sel;
    logic       m_imm_sel, s_imm_sel;
    logic [4:0] m_shamt, s_shamt;
    word_t      m_imm, s_imm;
    reg_addr_t  m_rs, s_rs;
    reg_addr_t  m_rt, s_rt;
    reg_addr_t  m_waddr, s_waddr;
    logic       m_wen, s_wen;
    logic       s_hazard;
    logic       pair_ok;
    lane_t      m_lane;
    lane_t      s_lane;

    decoder u_decoder_master (
        .inst_i      (head0_i),
        .alu_op_o    (m_alu_op),
        .shift_sel_o (m_shift_sel),
        .imm_sel_o   (m_imm_sel),
        .shamt_o     (m_shamt),
        .imm_value_o (m_imm),
        .rs_o        (m_rs),
        .rt_o        (m_rt),
        .waddr_o     (m_waddr),
        .wen_o       (m_wen)
    );

    decoder u_decoder_slave (
        .inst_i      (head1_i),
        .alu_op_o    (s_alu_op),
        .shift_sel_o (s_shift_sel),
        .imm_sel_o   (s_imm_sel),
        .shamt_o     (s_shamt),
        .imm_value_o (s_imm),
        .rs_o        (s_rs),
        .rt_o        (s_rt),
        .waddr_o     (s_waddr),
        .wen_o       (s_wen)
    );

    assign raddr0_o = m_rs;
    assign raddr1_o = m_rt;
    assign raddr2_o = s_rs;
    assign raddr3_o = s_rt;

    // later checks override earlier ones, so the youngest producer wins
    function automatic word_t forward(reg_addr_t addr, word_t rf_data);
        word_t value;
        value = rf_data;
        if (wb_wen0_i && (wb_waddr0_i == addr)) begin
            value = wb_data0_i;
        end
        if (wb_wen1_i && (wb_waddr1_i == addr)) begin
            value = wb_data1_i;
        end
        if (ex_wen0_i && (ex_waddr0_i == addr)) begin
            value = ex_result0_i;
        end
        if (ex_wen1_i && (ex_waddr1_i == addr)) begin
            value = ex_result1_i;
        end
        return value;
    endfunction

    // slave may not read what the master writes
    assign s_hazard = m_wen && ((s_rs == m_waddr) || (s_rt == m_waddr));
    assign pair_ok  = (count_i >= 2) && !s_hazard;

    always_comb begin
        m_lane.valid     = (count_i != '0);
        m_lane.alu_op    = m_alu_op;
        m_lane.shift_sel = m_shift_sel;
        m_lane.imm_sel   = m_imm_sel;
        m_lane.shamt     = m_shamt;
        m_lane.rs_value  = forward(m_rs, rdata0_i);
        m_lane.rt_value  = forward(m_rt, rdata1_i);
        m_lane.imm_value = m_imm;
        m_lane.waddr     = m_waddr;
        m_lane.wen       = m_wen;

        s_lane.valid     = pair_ok;
        s_lane.alu_op    = s_alu_op;
        s_lane.shift_sel = s_shift_sel;
        s_lane.imm_sel   = s_imm_sel;
        s_lane.shamt     = s_shamt;
        s_lane.rs_value  = forward(s_rs, rdata2_i);
        s_lane.rt_value  = forward(s_rt, rdata3_i);
        s_lane.imm_value = s_imm;
        s_lane.waddr     = s_waddr;
        s_lane.wen       = s_wen;
    end

    assign pop_one_o = m_lane.valid && !pair_ok;
    assign pop_two_o = pair_ok;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            issue_bus.master <= '0;
            issue_bus.slave  <= '0;
        end else begin
            issue_bus.master <= m_lane;
            issue_bus.slave  <= s_lane;
        end
    end

endmodule

/* issue/decoder.sv */
`timescale 1ns/100ps

module decoder import dual_issue_pkg::*; (
    input  word_t      inst_i,
    output alu_op_e    alu_op_o,
    output logic       shift_sel_o,
    output logic       imm_sel_o,
    output logic [4:0] shamt_o,
    output word_t      imm_value_o,
    output reg_addr_t  rs_o,
    output reg_addr_t  rt_o,
    output reg_addr_t  waddr_o,
    output logic       wen_o
);

    opcode_e              op;
    funct_e               funct;
    reg_addr_t            rd;
    logic [IMM_MSB:0]     imm;
    logic                 known;

    assign op      = opcode_e'(inst_i[OP_MSB:OP_LSB]);
    assign funct   = funct_e'(inst_i[FUNCT_MSB:FUNCT_LSB]);
    assign rs_o    = inst_i[RS_MSB:RS_LSB];
    assign rt_o    = inst_i[RT_MSB:RT_LSB];
    assign rd      = inst_i[RD_MSB:RD_LSB];
    assign shamt_o = inst_i[SHAMT_MSB:SHAMT_LSB];
    assign imm     = inst_i[IMM_MSB:IMM_LSB];

    always_comb begin
        alu_op_o    = ALU_ADD;
        imm_sel_o   = 1'b1;
        imm_value_o = {{(XLEN-IMM_MSB-1){imm[IMM_MSB]}}, imm};
        waddr_o     = rt_o;
        known       = 1'b1;
        case (op)
            OP_SPECIAL: begin
                imm_sel_o = 1'b0;
                waddr_o   = rd;
                case (funct)
                    F_SLL:   alu_op_o = ALU_SLL;
                    F_SRL:   alu_op_o = ALU_SRL;
                    F_SRA:   alu_op_o = ALU_SRA;
                    F_ADDU:  alu_op_o = ALU_ADD;
                    F_SUBU:  alu_op_o = ALU_SUB;
                    F_AND:   alu_op_o = ALU_AND;
                    F_OR:    alu_op_o = ALU_OR;
                    F_XOR:   alu_op_o = ALU_XOR;
                    F_NOR:   alu_op_o = ALU_NOR;
                    F_SLT:   alu_op_o = ALU_SLT;
                    F_SLTU:  alu_op_o = ALU_SLTU;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: alu_op_o = ALU_ADD;
            OP_SLTI:  alu_op_o = ALU_SLT;
            // sltiu still sign-extends, only the compare is unsigned
            OP_SLTIU: alu_op_o = ALU_SLTU;
            OP_ANDI: begin
                alu_op_o    = ALU_AND;
                imm_value_o = {{(XLEN-IMM_MSB-1){1'b0}}, imm};
            end
            OP_ORI: begin
                alu_op_o    = ALU_OR;
                imm_value_o = {{(XLEN-IMM_MSB-1){1'b0}}, imm};
            end
            OP_XORI: begin
                alu_op_o    = ALU_XOR;
                imm_value_o = {{(XLEN-IMM_MSB-1){1'b0}}, imm};
            end
            OP_LUI:   alu_op_o = ALU_LUI;
            default:  known = 1'b0;
        endcase
    end

    // constant shifts operate on rt
    assign shift_sel_o = (alu_op_o == ALU_SLL) || (alu_op_o == ALU_SRL) ||
                         (alu_op_o == ALU_SRA);

    // unknown words and r0 targets become no-ops
    assign wen_o = known && (waddr_o != '0);

endmodule

/* rtl/regfile.sv */
`timescale 1ns/100ps

module regfile import dual_issue_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  reg_addr_t raddr0_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    input  reg_addr_t raddr3_i,
    output word_t     rdata0_o,
    output word_t     rdata1_o,
    output word_t     rdata2_o,
    output word_t     rdata3_o,
    input  logic      wen0_i,
    input  reg_addr_t waddr0_i,
    input  word_t     wdata0_i,
    input  logic      wen1_i,
    input  reg_addr_t waddr1_i,
    input  word_t     wdata1_i
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wen0_i) begin
                regs[waddr0_i] <= wdata0_i;
            end
            // port 1 is the younger write, it wins on a clash
            if (wen1_i) begin
                regs[waddr1_i] <= wdata1_i;
            end
        end
    end

    // r0 reads zero
    assign rdata0_o = (raddr0_i == '0) ? '0 : regs[raddr0_i];
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];
    assign rdata3_o = (raddr3_i == '0) ? '0 : regs[raddr3_i];

endmodule

/* rtl/inst_queue.sv */
`timescale 1ns/100ps

module inst_queue import dual_issue_pkg::*; (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 push_valid_i,
    output logic                 push_ready_o,
    input  word_t                push_data_i,
    input  logic                 pop_one_i,
    input  logic                 pop_two_i,
    output word_t                head0_o,
    output word_t                head1_o,
    output logic [QUEUE_PTR_W:0] count_o
);

    word_t                  mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr_nxt;
    logic [QUEUE_PTR_W:0]   count;
    logic [QUEUE_PTR_W:0]   pop_cnt;
    logic                   push_fire;

    assign push_ready_o = (count != (QUEUE_PTR_W+1)'(QUEUE_DEPTH));
    assign push_fire    = push_valid_i && push_ready_o;
    assign count_o      = count;

    // pointers wrap on their own, depth is a power of two
    assign rd_ptr_nxt = rd_ptr + 1'b1;
    assign head0_o    = mem[rd_ptr];
    assign head1_o    = mem[rd_ptr_nxt];

    always_comb begin
        if (pop_two_i) begin
            pop_cnt = (QUEUE_PTR_W+1)'(2);
        end else if (pop_one_i) begin
            pop_cnt = (QUEUE_PTR_W+1)'(1);
        end else begin
            pop_cnt = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_ptr + pop_cnt[QUEUE_PTR_W-1:0];
            count  <= count + {{QUEUE_PTR_W{1'b0}}, push_fire} - pop_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

endmodule

/* common/issue_if.sv */
`timescale 1ns/100ps

interface issue_if import dual_issue_pkg::*; ();

    // decode-to-execute register contents
    lane_t master;
    lane_t slave;

    modport issue_mp (
        output master,
        output slave
    );

    modport exec_mp (
        input master,
        input slave
    );

endinterface

/* common/dual_issue_pkg.sv */
package dual_issue_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;
    localparam int QUEUE_DEPTH = 8;
    localparam int QUEUE_PTR_W = 3;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // instruction fields
    localparam int OP_MSB    = 31;
    localparam int OP_LSB    = 26;
    localparam int RS_MSB    = 25;
    localparam int RS_LSB    = 21;
    localparam int RT_MSB    = 20;
    localparam int RT_LSB    = 16;
    localparam int RD_MSB    = 15;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_MSB = 10;
    localparam int SHAMT_LSB = 6;
    localparam int FUNCT_MSB = 5;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_MSB   = 15;
    localparam int IMM_LSB   = 0;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    // one issued instruction, operands already forwarded
    typedef struct packed {
        logic       valid;
        alu_op_e    alu_op;
        logic       shift_sel;
        logic       imm_sel;
        logic [4:0] shamt;
        word_t      rs_value;
        word_t      rt_value;
        word_t      imm_value;
        reg_addr_t  waddr;
        logic       wen;
    } lane_t;

endpackage
